//--- hw/aes_core.sv
// Multi-cycle AES-128 encryption core reusing one round instance
// Start pulse at cycle t gives a one-cycle done pulse with the cipher block at t+13
`timescale 1ns/100ps
`default_nettype none

module aes_core (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            start_i,   // Begin encryption, only while idle
    input  wire aes_pkg::key_t   key_i,     // Cipher key, valid with start_i
    input  wire aes_pkg::block_t block_i,   // Plaintext, valid with start_i
    output logic                 done_o,    // One-cycle result strobe
    output aes_pkg::block_t      block_o    // Cipher block, valid with done_o
);
    import aes_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_ADD_KEY,   // Initial AddRoundKey
        S_ROUNDS,    // Rounds 1..9
        S_FINAL,     // Round 10
        S_DONE       // Load result register
    } state_t;

    state_t     state_q;
    round_idx_t round_q;     // Round being computed in S_ROUNDS
    block_t     aes_q;       // AES state between rounds
    block_t     result_q;    // Cipher block output
    logic       done_q;
    key_t       round_key;   // From the key schedule
    block_t     round_out;   // From the round logic

    // ------------------------------
    // Datapath blocks
    // ------------------------------

    // Round key r arrives r+1 cycles after start
    key_schedule u_key_schedule (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start_i),
        .key_i       (key_i),
        .round_key_o (round_key)
    );

    aes_round u_aes_round (
        .state_i     (aes_q),
        .round_key_i (round_key),
        .final_i     (state_q == S_FINAL),
        .state_o     (round_out)
    );

    // ------------------------------
    // Control FSM
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
            round_q <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;                            // Pulse by default
            case (state_q)
                S_IDLE: begin
                    if (start_i) begin
                        state_q <= S_ADD_KEY;
                        round_q <= 4'd1;
                    end
                end
                S_ADD_KEY: state_q <= S_ROUNDS;
                S_ROUNDS: begin
                    round_q <= round_q + 4'd1;
                    if (round_q == round_idx_t'(NUM_ROUNDS - 1)) begin
                        state_q <= S_FINAL;            // Ninth round done
                    end
                end
                S_FINAL: state_q <= S_DONE;
                S_DONE: begin
                    state_q <= S_IDLE;
                    done_q  <= 1'b1;                   // Valid with result_q
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // State and result registers
    always_ff @(posedge clk) begin
        case (state_q)
            S_IDLE:    if (start_i) aes_q <= block_i;  // Latch plaintext
            S_ADD_KEY: aes_q <= aes_q ^ round_key;     // Round key 0
            S_ROUNDS,
            S_FINAL:   aes_q <= round_out;
            S_DONE:    result_q <= aes_q;
            default:   ;
        endcase
    end

    assign done_o  = done_q;
    assign block_o = result_q;

    // Controller must wait for done before the next start
    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        start_i |-> state_q == S_IDLE);

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |=> !done_o);

endmodule

`default_nettype wire

//--- hw/aes_pkg.sv
// Shared AES-128 types, round constants and GF(2^8) helpers
// Imported by every RTL block of the CBC-MAC engine and by the testbench model
`default_nettype none

package aes_pkg;

    typedef logic [127:0] block_t;      // State or data block, byte 0 in the MSB
    typedef logic [127:0] key_t;        // Cipher key or round key
    typedef logic [7:0]   byte_t;       // One state byte
    typedef logic [3:0]   round_idx_t;  // Round number 0..10

    localparam int NUM_ROUNDS = 10;     // AES-128

    // ------------------------------
    // GF(2^8) arithmetic
    // ------------------------------

    // Multiply by x modulo x^8 + x^4 + x^3 + x + 1
    function automatic byte_t xtime(byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // Shift-and-add multiply
    function automatic byte_t gf_mul(byte_t a, byte_t b);
        byte_t p;
        byte_t x;
        p = 8'h00;
        x = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) p = p ^ x;     // Add current power of a
            x = xtime(x);
        end
        return p;
    endfunction

    // Inverse as a^254, zero maps to zero
    function automatic byte_t gf_inv(byte_t a);
        byte_t res;
        byte_t sq;
        res = 8'h01;
        sq  = a;
        for (int i = 1; i < 8; i++) begin
            sq  = gf_mul(sq, sq);    // a^2, a^4 ... a^128
            res = gf_mul(res, sq);
        end
        return res;
    endfunction

    // ------------------------------
    // Cipher primitives
    // ------------------------------

    // Forward S-box: inverse followed by the affine map
    function automatic byte_t sbox(byte_t a);
        byte_t b;
        b = gf_inv(a);
        return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]}
                 ^ {b[3:0], b[7:4]} ^ 8'h63;
    endfunction

    // Round constant for rounds 1..10
    function automatic byte_t rcon(round_idx_t r);
        case (r)
            4'd1:    return 8'h01;
            4'd2:    return 8'h02;
            4'd3:    return 8'h04;
            4'd4:    return 8'h08;
            4'd5:    return 8'h10;
            4'd6:    return 8'h20;
            4'd7:    return 8'h40;
            4'd8:    return 8'h80;
            4'd9:    return 8'h1b;
            4'd10:   return 8'h36;
            default: return 8'h00;   // Round 0 and unused codes
        endcase
    endfunction

endpackage

`default_nettype wire

//--- hw/aes_round.sv
// Combinational AES encryption round
// SubBytes, ShiftRows, MixColumns (skipped in the final round), AddRoundKey
`timescale 1ns/100ps
`default_nettype none

module aes_round (
    input  wire aes_pkg::block_t state_i,      // State entering the round
    input  wire aes_pkg::key_t   round_key_i,  // Key of this round
    input  wire logic            final_i,      // Last round, no MixColumns
    output aes_pkg::block_t      state_o       // State leaving the round
);
    import aes_pkg::*;

    byte_t sb [16];   // After SubBytes
    byte_t sr [16];   // After ShiftRows
    byte_t mc [16];   // After MixColumns

    always_comb begin
        // Byte i sits at row i%4, column i/4
        for (int i = 0; i < 16; i++) begin
            sb[i] = sbox(state_i[127-8*i -: 8]);
        end

        // ------------------------------
        // ShiftRows
        // ------------------------------
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                sr[4*c+r] = sb[4*((c+r)%4)+r];                // Row r rotates left by r
            end
        end

        // ------------------------------
        // MixColumns
        // ------------------------------
        for (int c = 0; c < 4; c++) begin
            mc[4*c]   = xtime(sr[4*c]) ^ xtime(sr[4*c+1]) ^ sr[4*c+1]
                      ^ sr[4*c+2] ^ sr[4*c+3];                // 2 3 1 1
            mc[4*c+1] = sr[4*c] ^ xtime(sr[4*c+1]) ^ xtime(sr[4*c+2])
                      ^ sr[4*c+2] ^ sr[4*c+3];                // 1 2 3 1
            mc[4*c+2] = sr[4*c] ^ sr[4*c+1] ^ xtime(sr[4*c+2])
                      ^ xtime(sr[4*c+3]) ^ sr[4*c+3];         // 1 1 2 3
            mc[4*c+3] = xtime(sr[4*c]) ^ sr[4*c] ^ sr[4*c+1]
                      ^ sr[4*c+2] ^ xtime(sr[4*c+3]);         // 3 1 1 2
        end

        // AddRoundKey, final round bypasses MixColumns
        for (int i = 0; i < 16; i++) begin
            state_o[127-8*i -: 8] = (final_i ? sr[i] : mc[i]) ^ round_key_i[127-8*i -: 8];
        end
    end

endmodule

`default_nettype wire

//--- hw/cbcmac_ctrl.sv
// CBC-MAC control with the block and MAC four-phase handshakes
// Holds the chaining value and message key, and feeds one block at a time to the core
`timescale 1ns/100ps
`default_nettype none

module cbcmac_ctrl (
    input  wire logic            clk,
    input  wire logic            rst_n,
    // Host block handshake
    input  wire logic            blk_req_i,
    input  wire logic            last_i,        // Block ends the message
    input  wire aes_pkg::key_t   key_i,         // Used on the first block only
    input  wire aes_pkg::block_t blk_i,
    output logic                 blk_ack_o,
    // Host MAC handshake
    output logic                 mac_req_o,
    input  wire logic            mac_ack_i,
    output aes_pkg::block_t      mac_o,
    // AES core
    output logic                 core_start_o,
    output aes_pkg::key_t        core_key_o,
    output aes_pkg::block_t      core_block_o,
    input  wire logic            core_done_i,
    input  wire aes_pkg::block_t core_block_i
);
    import aes_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,       // Wait for a block request
        S_BUSY,       // Core encrypting
        S_BLK_ACK,    // Ack high, wait for request low
        S_MAC_WAIT    // Wait for the MAC handshake to finish
    } state_t;

    state_t state_q;
    block_t chain_q;      // Chaining value, also the MAC
    key_t   key_q;        // Key of the current message
    block_t in_q;         // Chaining value XOR message block
    logic   first_q;      // Next block starts a message
    logic   last_q;       // Block in flight is the last one
    logic   start_q;
    logic   blk_ack_q;
    logic   mac_req_q;

    wire accept = (state_q == S_IDLE) && blk_req_i;

    // ------------------------------
    // Handshake FSM
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= S_IDLE;
            chain_q   <= '0;
            first_q   <= 1'b1;
            last_q    <= 1'b0;
            start_q   <= 1'b0;
            blk_ack_q <= 1'b0;
            mac_req_q <= 1'b0;
        end else begin
            start_q <= 1'b0;
            if (mac_req_q && mac_ack_i) mac_req_q <= 1'b0;   // Host took the MAC
            case (state_q)
                S_IDLE: begin
                    if (blk_req_i) begin
                        start_q <= 1'b1;                     // Core start next cycle
                        last_q  <= last_i;
                        first_q <= 1'b0;
                        state_q <= S_BUSY;
                    end
                end
                S_BUSY: begin
                    if (core_done_i) begin
                        chain_q   <= core_block_i;           // New chaining value
                        blk_ack_q <= 1'b1;
                        mac_req_q <= last_q;                 // MAC offered with the ack
                        state_q   <= S_BLK_ACK;
                    end
                end
                S_BLK_ACK: begin
                    if (!blk_req_i) begin
                        blk_ack_q <= 1'b0;
                        state_q   <= last_q ? S_MAC_WAIT : S_IDLE;
                    end
                end
                S_MAC_WAIT: begin
                    // Both MAC lines low ends the message
                    if (!mac_req_q && !mac_ack_i) begin
                        chain_q <= '0;
                        first_q <= 1'b1;
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // Core operands
    always_ff @(posedge clk) begin
        if (accept) begin
            in_q <= chain_q ^ blk_i;
            if (first_q) key_q <= key_i;                     // Key only at message start
        end
    end

    assign blk_ack_o    = blk_ack_q;
    assign mac_req_o    = mac_req_q;
    assign mac_o        = chain_q;
    assign core_start_o = start_q;
    assign core_key_o   = key_q;
    assign core_block_o = in_q;

    // ------------------------------
    // Protocol checks
    // ------------------------------
    a_ack_with_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(blk_ack_o) |-> blk_req_i);

    a_mac_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mac_req_o |=> !mac_req_o || $stable(mac_o));

endmodule

`default_nettype wire

//--- hw/cbcmac_top.sv
// AES-128 CBC-MAC engine top level
// Host sends blocks over one req/ack handshake and takes the MAC over another
`timescale 1ns/100ps
`default_nettype none

module cbcmac_top (
    input  wire logic            clk,
    input  wire logic            rst_n,
    // Block handshake
    input  wire logic            blk_req_i,
    input  wire logic            last_i,
    input  wire aes_pkg::key_t   key_i,
    input  wire aes_pkg::block_t blk_i,
    output logic                 blk_ack_o,
    // MAC handshake
    output logic                 mac_req_o,
    input  wire logic            mac_ack_i,
    output aes_pkg::block_t      mac_o
);
    import aes_pkg::*;

    // ------------------------------
    // Control to core
    // ------------------------------
    logic   core_start;
    key_t   core_key;
    block_t core_block_in;    // Plaintext to the core
    logic   core_done;
    block_t core_block_out;   // Cipher block back

    cbcmac_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .blk_req_i    (blk_req_i),
        .last_i       (last_i),
        .key_i        (key_i),
        .blk_i        (blk_i),
        .blk_ack_o    (blk_ack_o),
        .mac_req_o    (mac_req_o),
        .mac_ack_i    (mac_ack_i),
        .mac_o        (mac_o),
        .core_start_o (core_start),
        .core_key_o   (core_key),
        .core_block_o (core_block_in),
        .core_done_i  (core_done),
        .core_block_i (core_block_out)
    );

    aes_core u_aes_core (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (core_start),
        .key_i   (core_key),
        .block_i (core_block_in),
        .done_o  (core_done),
        .block_o (core_block_out)
    );

endmodule

`default_nettype wire

//--- hw/key_schedule.sv
// On-the-fly AES-128 key expansion
// Start loads the cipher key as round key 0, then one new round key per cycle
`timescale 1ns/100ps
`default_nettype none

module key_schedule (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          start_i,      // Load new cipher key
    input  wire aes_pkg::key_t key_i,        // Cipher key, valid with start_i
    output aes_pkg::key_t      round_key_o   // Round key of the current round
);
    import aes_pkg::*;

    key_t       rk_q;      // Current round key
    round_idx_t cnt_q;     // Index of rk_q
    key_t       rk_next;   // Next round key
    logic [31:0] temp;     // SubWord(RotWord(w3)) ^ Rcon

    // ------------------------------
    // Next round key
    // ------------------------------
    always_comb begin
        temp = {rk_q[23:0], rk_q[31:24]};                     // RotWord of w3
        for (int i = 0; i < 4; i++) begin
            temp[8*i +: 8] = sbox(temp[8*i +: 8]);            // SubWord
        end
        temp[31:24] = temp[31:24] ^ rcon(round_idx_t'(cnt_q + 4'd1));
        rk_next[127:96] = rk_q[127:96] ^ temp;
        rk_next[95:64]  = rk_q[95:64]  ^ rk_next[127:96];
        rk_next[63:32]  = rk_q[63:32]  ^ rk_next[95:64];
        rk_next[31:0]   = rk_q[31:0]   ^ rk_next[63:32];
    end

    // Round counter, parks at the last round
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt_q <= round_idx_t'(NUM_ROUNDS);
        end else if (start_i) begin
            cnt_q <= '0;
        end else if (cnt_q < round_idx_t'(NUM_ROUNDS)) begin
            cnt_q <= cnt_q + 4'd1;
        end
    end

    // Round key register
    always_ff @(posedge clk) begin
        if (start_i) begin
            rk_q <= key_i;                                    // Round key 0
        end else if (cnt_q < round_idx_t'(NUM_ROUNDS)) begin
            rk_q <= rk_next;
        end
    end

    assign round_key_o = rk_q;

    // Counter stays inside the round range
    a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
        cnt_q <= round_idx_t'(NUM_ROUNDS));

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Builds the CBC-MAC testbench with Verilator and runs it.
# The exit status is zero only when the simulation passes.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
    --top-module cbcmac_tb -f sources.f -o cbcmac_sim &&
./obj_dir/cbcmac_sim ||
{ echo "Build or simulation failed"; exit 1; }

//--- sources.f
hw/aes_pkg.sv
hw/key_schedule.sv
hw/aes_round.sv
hw/aes_core.sv
hw/cbcmac_ctrl.sv
hw/cbcmac_top.sv
+incdir+testbench
testbench/cbcmac_tb.sv

//--- testbench/cbcmac_model.svh
// Reference AES-128 encryption and CBC-MAC chaining step for the testbench
// Included inside the testbench module, after the aes_pkg import
`ifndef CBCMAC_MODEL_SVH
`define CBCMAC_MODEL_SVH

// FIPS-197 encryption on a [row][column] byte matrix
function automatic block_t encrypt_block(key_t key, block_t pt);
    logic [31:0] w [44];      // Expanded key words
    byte_t       st [4][4];   // State as [row][column]
    byte_t       sh [4][4];   // After SubBytes and ShiftRows
    byte_t       col [4];     // One column for MixColumns
    byte_t       rc;          // Round constant, doubled each round
    logic [31:0] t;
    block_t      ct;

    // ------------------------------
    // Key expansion, word by word
    // ------------------------------
    rc = 8'h01;
    for (int i = 0; i < 4; i++) begin
        w[i] = key[127-32*i -: 32];
    end
    for (int i = 4; i < 44; i++) begin
        t = w[i-1];
        if (i % 4 == 0) begin
            // RotWord, SubWord, Rcon on the top byte
            t = {sbox(t[23:16]) ^ rc, sbox(t[15:8]), sbox(t[7:0]), sbox(t[31:24])};
            rc = xtime(rc);
        end
        w[i] = w[i-4] ^ t;
    end

    // Byte 4c+r of the block goes to row r, column c
    for (int c = 0; c < 4; c++) begin
        for (int r = 0; r < 4; r++) begin
            st[r][c] = pt[127-8*(4*c+r) -: 8] ^ w[c][31-8*r -: 8];   // Round key 0
        end
    end

    for (int rnd = 1; rnd <= 10; rnd++) begin
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                sh[r][c] = sbox(st[r][(c + r) % 4]);   // Row r rotated left by r
            end
        end
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                col[r] = sh[r][c];
            end
            for (int r = 0; r < 4; r++) begin
                if (rnd < 10) begin
                    // Circulant 2 3 1 1, rotated by row
                    st[r][c] = xtime(col[r]) ^ xtime(col[(r+1)%4]) ^ col[(r+1)%4]
                             ^ col[(r+2)%4] ^ col[(r+3)%4];
                end else begin
                    st[r][c] = col[r];                 // No MixColumns in round 10
                end
                st[r][c] = st[r][c] ^ w[4*rnd+c][31-8*r -: 8];
            end
        end
    end

    for (int c = 0; c < 4; c++) begin
        for (int r = 0; r < 4; r++) begin
            ct[127-8*(4*c+r) -: 8] = st[r][c];
        end
    end
    return ct;
endfunction

// One CBC-MAC step, the block XORed into the chaining value and encrypted
function automatic block_t chain_block(block_t chain, key_t key, block_t blk);
    return encrypt_block(key, chain ^ blk);
endfunction

`endif

//--- testbench/cbcmac_tb.sv
// Testbench for the AES-128 CBC-MAC engine
// Directed known-answer and handshake cases followed by random messages against the model
`timescale 1ns/100ps
`default_nettype none

module cbcmac_tb;
    import aes_pkg::*;

    `include "cbcmac_model.svh"

    localparam int     RAND_MSGS        = 30;
    localparam int     DIRECTED_MSGS    = 5;
    localparam int     TOTAL_MSGS       = RAND_MSGS + DIRECTED_MSGS;
    localparam int     MAX_BLOCKS       = 4;
    localparam int     CYCLES_PER_BLOCK = 200;
    localparam int     WATCHDOG_CYCLES  = TOTAL_MSGS * MAX_BLOCKS * CYCLES_PER_BLOCK;
    localparam int     BLOCK_LATENCY    = 15;   // blk_req_i to blk_ack_o on an idle engine
    localparam key_t   KAT_KEY = 128'h000102030405060708090a0b0c0d0e0f;
    localparam block_t KAT_PT  = 128'h00112233445566778899aabbccddeeff;
    localparam block_t KAT_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;   // FIPS-197 C.1

    logic   clk;
    logic   rst_n;
    logic   blk_req;
    logic   last_blk;
    key_t   msg_key;
    block_t blk_data;
    logic   blk_ack;
    logic   mac_req;
    logic   mac_ack;
    block_t mac_val;

    int     mac_delay_cycles = 0;     // Forced responder delay or 0 for a random one
    int     mac_done_cnt = 0;         // Completed MAC handshakes
    int     msgs_sent = 0;
    block_t exp_q [$];                // Expected MACs in message order
    block_t mac_log [$];              // MACs taken from the DUT
    block_t msg_blks [MAX_BLOCKS];    // Blocks of the message being sent

    cbcmac_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .blk_req_i (blk_req),
        .last_i    (last_blk),
        .key_i     (msg_key),
        .blk_i     (blk_data),
        .blk_ack_o (blk_ack),
        .mac_req_o (mac_req),
        .mac_ack_i (mac_ack),
        .mac_o     (mac_val)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("CHECK FAILED %s: got %h expected %h", name, got, expected));
        end
    endtask

    function automatic block_t rand_block();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    task automatic wait_macs(input int n);
        while (mac_done_cnt < n) begin
            @(negedge clk);
        end
    endtask

    // One four-phase block transfer
    // Latency counts the cycles with req high and ack still low
    task automatic send_block(input key_t k, input block_t b, input logic is_last,
                              output int lat, output int macs_at_ack);
        @(posedge clk);
        msg_key  <= k;
        blk_data <= b;
        last_blk <= is_last;
        blk_req  <= 1'b1;
        lat = 0;
        do begin
            @(negedge clk);
            if (!blk_ack) lat++;
        end while (!blk_ack);
        macs_at_ack = mac_done_cnt;
        check_value("mac_req_o with blk_ack_o", 128'(mac_req), 128'(is_last));
        @(posedge clk);
        blk_req <= 1'b0;
        do begin
            @(negedge clk);
        end while (blk_ack);                              // Ack drops after req
    endtask

    task automatic send_message(input key_t k, input int n, input logic hold_expected);
        block_t chain;
        int     lat;
        int     macs;
        chain = '0;                                       // Fresh chain per message
        for (int i = 0; i < n; i++) begin
            chain = chain_block(chain, k, msg_blks[i]);
        end
        exp_q.push_back(chain);
        for (int i = 0; i < n; i++) begin
            // Later blocks carry a junk key that the DUT must ignore
            send_block(i == 0 ? k : rand_block(), msg_blks[i], i == n - 1, lat, macs);
            if (i == 0 && msgs_sent > 0) begin
                check_value("MAC handshakes done at blk_ack_o", 128'(macs), 128'(msgs_sent));
                if (hold_expected) begin
                    check_value("blk_ack_o held back by mac_ack_i",
                                128'(lat > BLOCK_LATENCY), 128'(1));
                end
            end else begin
                check_value("blk_ack_o latency", 128'(lat), 128'(BLOCK_LATENCY));
            end
        end
        msgs_sent++;
    endtask

    // ------------------------------
    // MAC responder
    // ------------------------------
    initial begin : mac_responder
        block_t held;
        int     delay;
        mac_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (rst_n && mac_req) begin
                if (exp_q.size() == 0) begin
                    abort_run("The DUT offered a MAC while no message was outstanding");
                end else begin
                    held = mac_val;
                    check_value("mac_o", held, exp_q.pop_front());
                    mac_log.push_back(held);
                    delay = (mac_delay_cycles > 0) ? mac_delay_cycles : $urandom_range(0, 5);
                    repeat (delay) begin
                        @(negedge clk);
                        check_value("mac_o while mac_req_o high", mac_val, held);
                    end
                    @(posedge clk);
                    mac_ack <= 1'b1;
                    do begin
                        @(negedge clk);
                        if (mac_req) check_value("mac_o while mac_req_o high", mac_val, held);
                    end while (mac_req);
                    @(posedge clk);
                    mac_ack <= 1'b0;
                    mac_done_cnt++;                       // Handshake complete
                end
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("Timeout: the run did not finish within its cycle budget");
    end

    // ------------------------------
    // Host sequence
    // ------------------------------
    initial begin : host
        int unsigned seed_val;
        int          n_blks;
        seed_val = $urandom(42);
        rst_n    = 1'b0;
        blk_req  = 1'b0;
        last_blk = 1'b0;
        msg_key  = '0;
        blk_data = '0;

        check_value("reference model known answer", encrypt_block(KAT_KEY, KAT_PT), KAT_CT);

        // Reset held over 4 rising edges with both acks low throughout
        repeat (3) begin
            @(posedge clk);
            @(negedge clk);
            check_value("blk_ack_o in reset", 128'(blk_ack), 128'(0));
            check_value("mac_req_o in reset", 128'(mac_req), 128'(0));
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("blk_ack_o after reset", 128'(blk_ack), 128'(0));
        check_value("mac_req_o after reset", 128'(mac_req), 128'(0));
        check_value("mac_o after reset", mac_val, '0);

        // Known answer and the same block twice more
        for (int m = 0; m < 3; m++) begin
            msg_blks[0] = KAT_PT;
            send_message(KAT_KEY, 1, 1'b0);
        end
        wait_macs(3);
        for (int m = 0; m < 3; m++) begin
            check_value("mac_o known answer", mac_log[m], KAT_CT);
        end

        // Slow MAC acks stall the next message
        mac_delay_cycles = 25;
        msg_blks[0] = rand_block();
        msg_blks[1] = rand_block();
        send_message(rand_block(), 2, 1'b0);
        msg_blks[0] = rand_block();
        send_message(rand_block(), 1, 1'b1);
        wait_macs(DIRECTED_MSGS);
        mac_delay_cycles = 0;

        for (int m = 0; m < RAND_MSGS; m++) begin
            n_blks = $urandom_range(1, MAX_BLOCKS);
            for (int i = 0; i < n_blks; i++) begin
                msg_blks[i] = rand_block();
            end
            send_message(rand_block(), n_blks, 1'b0);
        end
        wait_macs(TOTAL_MSGS);

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire
